// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - isaPkg.sv
  - pipePkg.sv
  - stageIf.sv
  - InstructionFetch.sv
  - InstructionDecode.sv
  - Execute.sv
  - Memory.sv
  - CPU.sv
  - target: test
    files:
      - cpu_checker.sv
      - cpuTb.sv

// ==== CPU.sv ====
module CPU import isaPkg::*;
#(
	parameter word_t resetPc = '0
)
(
	input logic clk,
	input logic reset,
	output logic iCyc,
	output logic iStb,
	output word_t iAdr,
	input word_t iDatRd,
	input logic iAck,
	output logic dCyc,
	output logic dStb,
	output logic dWe,
	output word_t dAdr,
	output word_t dDatWr,
	input word_t dDatRd,
	input logic dAck,
	output logic hlt,
	output word_t pc
);
	word_t instr;
	word_t pcNext;
	word_t target;
	word_t wbData;
	regAddr_t wbAddr;
	logic instrValid;
	logic redirect;
	logic memHold;
	logic decodeStall;
	logic wbWe;

	idExIf idEx();
	exMemIf exMem();

	InstructionFetch #(.resetPc(resetPc)) u_fetch (
		.clk(clk), .reset(reset),
		.iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatRd(iDatRd), .iAck(iAck),
		.redirect(redirect), .target(target), .hold(memHold || decodeStall),
		.instr(instr), .instrValid(instrValid), .pcNext(pcNext), .pc(pc));

	InstructionDecode u_decode (
		.clk(clk), .reset(reset),
		.instr(instr), .instrValid(instrValid), .pcNext(pcNext),
		.flush(redirect), .memHold(memHold),
		.wbWe(wbWe), .wbAddr(wbAddr), .wbData(wbData),
		.decodeStall(decodeStall), .idEx(idEx), .exMemDest(exMem));

	Execute u_execute (
		.clk(clk), .reset(reset), .idEx(idEx), .memHold(memHold),
		.exMem(exMem), .redirect(redirect), .target(target));

	Memory u_memory (
		.clk(clk), .reset(reset), .exMem(exMem),
		.dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatWr(dDatWr),
		.dDatRd(dDatRd), .dAck(dAck), .memHold(memHold),
		.wbWe(wbWe), .wbAddr(wbAddr), .wbData(wbData), .hlt(hlt));
endmodule

// ==== Execute.sv ====
module Execute import isaPkg::*, pipePkg::*;
(
	input logic clk,
	input logic reset,
	idExIf.consumer idEx,
	input logic memHold,
	exMemIf.producer exMem,
	output logic redirect,
	output word_t target
);
	word_t srcB;
	word_t result;
	logic useImm;
	logic setsV, setsZn;
	logic vNext;
	logic zFlag, nFlag, vFlag;
	logic taken;

	assign useImm = idEx.opcode inside {opSll, opSrl, opLw, opSw, opLlb, opLhb};
	assign srcB = useImm ? idEx.imm : idEx.opB;

	always_comb
	begin
		result = '0;
		vNext = 1'b0;
		case (idEx.aluOp)
			aluAdd:
			begin
				result = idEx.opA + srcB;
				vNext = (idEx.opA[15] == srcB[15]) && (result[15] != idEx.opA[15]);
			end
			aluSub:
			begin
				result = idEx.opA - srcB;
				vNext = (idEx.opA[15] != srcB[15]) && (result[15] != idEx.opA[15]);
			end
			aluNand:
				result = ~(idEx.opA & srcB);
			aluXor:
				result = idEx.opA ^ srcB;
			aluSll:
				result = idEx.opA << srcB[3:0];
			aluSrl:
				result = idEx.opA >> srcB[3:0];
			aluPassLow:
				result = srcB;
			aluMergeHigh:
				result = {srcB[7:0], idEx.opA[7:0]};
			default:
				result = '0;
		endcase
	end

	// ADD and SUB set all flags, the logic ops only Z and N
	assign setsV = idEx.opcode inside {opAdd, opSub};
	assign setsZn = setsV || (idEx.opcode inside {opNand, opXor, opSll, opSrl});

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			zFlag <= 1'b0;
			nFlag <= 1'b0;
			vFlag <= 1'b0;
		end
		else if (idEx.valid && !memHold)
		begin
			if (setsZn)
			begin
				zFlag <= (result == '0);
				nFlag <= result[15];
			end
			if (setsV)
				vFlag <= vNext;
		end
	end

	// branch tests the flags left by older instructions
	always_comb
	begin
		case (idEx.cond)
			condNeq: taken = !zFlag;
			condEq: taken = zFlag;
			condGt: taken = !zFlag && !nFlag;
			condLt: taken = nFlag;
			condGte: taken = !nFlag;
			condLte: taken = nFlag || zFlag;
			condOv: taken = vFlag;
			default: taken = 1'b1;
		endcase
	end

	assign redirect = idEx.valid && idEx.opcode == opB && taken && !memHold;
	assign target = idEx.pcNext + idEx.imm;

	// EX/MEM register
	always_ff @(posedge clk)
	begin
		if (reset)
			exMem.valid <= 1'b0;
		else if (!memHold)
			exMem.valid <= idEx.valid;
	end

	always_ff @(posedge clk)
	begin
		if (!memHold)
		begin
			exMem.result <= result;
			exMem.storeData <= idEx.storeVal;
			exMem.dest <= idEx.dest;
			exMem.regWe <= idEx.regWe;
			exMem.memRe <= idEx.memRe;
			exMem.memWe <= idEx.memWe;
			exMem.wbSrc <= idEx.wbSrc;
			exMem.halt <= idEx.halt;
		end
	end
endmodule

// ==== InstructionDecode.sv ====
module InstructionDecode import isaPkg::*, pipePkg::*;
(
	input logic clk,
	input logic reset,
	input word_t instr,
	input logic instrValid,
	input word_t pcNext,
	input logic flush,
	input logic memHold,
	input logic wbWe,
	input regAddr_t wbAddr,
	input word_t wbData,
	output logic decodeStall,
	idExIf.producer idEx,
	exMemIf.monitor exMemDest
);
	word_t regs [16];
	opcode_t op;
	regAddr_t rd;
	regAddr_t srcA;
	regAddr_t srcB;
	aluOp_t aluOp;
	wbSrc_t wbSrc;
	word_t imm;
	word_t valA;
	word_t valB;
	logic regWe, memRe, memWe, halt;
	logic useA, useB;
	logic pendIdEx, pendExMem, hazardA, hazardB;

	assign op = opOf(instr);
	assign rd = rdOf(instr);

	// ***********************************************
	// control decode
	// ***********************************************
	always_comb
	begin
		aluOp = aluAdd;
		wbSrc = wbAlu;
		imm = '0;
		regWe = 1'b0;
		memRe = 1'b0;
		memWe = 1'b0;
		halt = 1'b0;
		useA = 1'b0;
		useB = 1'b0;
		srcA = rsOf(instr);
		srcB = rtOf(instr);
		case (op)
			opAdd, opSub, opNand, opXor:
			begin
				aluOp = aluOp_t'(instr[14:12]);
				regWe = 1'b1;
				useA = 1'b1;
				useB = 1'b1;
			end
			opSll, opSrl:
			begin
				aluOp = aluOp_t'(instr[14:12]);
				imm = {12'd0, instr[3:0]};
				regWe = 1'b1;
				useA = 1'b1;
			end
			opLw:
			begin
				imm = {{12{instr[3]}}, instr[3:0]};
				regWe = 1'b1;
				memRe = 1'b1;
				wbSrc = wbLoad;
				useA = 1'b1;
			end
			opSw:
			begin
				// second port reads the store value from rd
				imm = {{12{instr[3]}}, instr[3:0]};
				memWe = 1'b1;
				useA = 1'b1;
				useB = 1'b1;
				srcB = rd;
			end
			opLlb:
			begin
				aluOp = aluPassLow;
				imm = {{8{instr[7]}}, instr[7:0]};
				regWe = 1'b1;
			end
			opLhb:
			begin
				aluOp = aluMergeHigh;
				imm = {8'd0, instr[7:0]};
				regWe = 1'b1;
				useA = 1'b1;
				srcA = rd;
			end
			opB:
				imm = {{7{instr[8]}}, instr[8:0]};
			opHlt:
				halt = 1'b1;
			default:
				;
		endcase
	end

	// register file with write-through of the retiring result
	assign valA = (srcA == '0) ? '0 : (wbWe && wbAddr == srcA) ? wbData : regs[srcA];
	assign valB = (srcB == '0) ? '0 : (wbWe && wbAddr == srcB) ? wbData : regs[srcB];

	always_ff @(posedge clk)
	begin
		if (wbWe && wbAddr != '0)
			regs[wbAddr] <= wbData;
	end

	// ***********************************************
	// interlock
	// ***********************************************
	assign pendIdEx = idEx.valid && idEx.regWe && idEx.dest != '0;
	// an EX/MEM result retiring this cycle comes through the write-through path
	assign pendExMem = exMemDest.valid && exMemDest.regWe && exMemDest.dest != '0 && !wbWe;
	assign hazardA = useA && ((pendIdEx && idEx.dest == srcA)
		|| (pendExMem && exMemDest.dest == srcA));
	assign hazardB = useB && ((pendIdEx && idEx.dest == srcB)
		|| (pendExMem && exMemDest.dest == srcB));
	assign decodeStall = instrValid && (hazardA || hazardB);

	// ID/EX register, a bubble on stall or flush
	always_ff @(posedge clk)
	begin
		if (reset)
			idEx.valid <= 1'b0;
		else if (!memHold)
			idEx.valid <= instrValid && !decodeStall && !flush;
	end

	always_ff @(posedge clk)
	begin
		if (!memHold)
		begin
			idEx.opcode <= op;
			idEx.aluOp <= aluOp;
			idEx.opA <= valA;
			idEx.opB <= valB;
			idEx.storeVal <= valB;
			idEx.imm <= imm;
			idEx.dest <= rd;
			idEx.regWe <= regWe;
			idEx.memRe <= memRe;
			idEx.memWe <= memWe;
			idEx.wbSrc <= wbSrc;
			idEx.cond <= condOf(instr);
			idEx.pcNext <= pcNext;
			idEx.halt <= halt;
		end
	end
endmodule

// ==== InstructionFetch.sv ====
module InstructionFetch import isaPkg::*, pipePkg::*;
#(
	parameter word_t resetPc = '0
)
(
	input logic clk,
	input logic reset,
	output logic iCyc,
	output logic iStb,
	output word_t iAdr,
	input word_t iDatRd,
	input logic iAck,
	input logic redirect,
	input word_t target,
	input logic hold,
	output word_t instr,
	output logic instrValid,
	output word_t pcNext,
	output word_t pc
);
	fetchState_t state;
	word_t pcReg;
	word_t adrReg;
	logic discard;
	logic accept;

	assign iCyc = (state == fetchRequest);
	assign iStb = (state == fetchRequest);
	assign iAdr = adrReg;
	assign pc = pcReg;

	// a word acked across a redirect is dropped
	assign accept = iStb && iAck && !discard && !redirect;

	// ***********************************************
	// bus cycle and program counter
	// ***********************************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= fetchIdle;
			pcReg <= resetPc;
			discard <= 1'b0;
			instrValid <= 1'b0;
		end
		else
		begin
			case (state)
				fetchIdle:
					if (redirect)
						pcReg <= target;
					else if (!(instrValid && hold))
					begin
						// IF/ID is empty or drains this edge
						adrReg <= pcReg;
						state <= fetchRequest;
					end
				fetchRequest:
					if (iAck)
					begin
						state <= fetchIdle;
						discard <= 1'b0;
						if (redirect)
							pcReg <= target;
						else if (accept)
						begin
							pcReg <= pcReg + 16'd1;
							if (opOf(iDatRd) == opHlt)
								state <= fetchHalted;
						end
					end
					else if (redirect)
					begin
						// cycle must finish first
						pcReg <= target;
						discard <= 1'b1;
					end
				fetchHalted:
					if (redirect)
					begin
						pcReg <= target;
						state <= fetchIdle;
					end
				default:
					state <= fetchIdle;
			endcase

			if (redirect)
				instrValid <= 1'b0;
			else if (accept)
				instrValid <= 1'b1;
			else if (!hold)
				instrValid <= 1'b0;
		end
	end

	// IF/ID payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			instr <= iDatRd;
			pcNext <= pcReg + 16'd1;
		end
	end
endmodule

// ==== Memory.sv ====
module Memory import isaPkg::*, pipePkg::*;
(
	input logic clk,
	input logic reset,
	exMemIf.consumer exMem,
	output logic dCyc,
	output logic dStb,
	output logic dWe,
	output word_t dAdr,
	output word_t dDatWr,
	input word_t dDatRd,
	input logic dAck,
	output logic memHold,
	output logic wbWe,
	output regAddr_t wbAddr,
	output word_t wbData,
	output logic hlt
);
	logic memAccess;
	logic retire;

	// one bus cycle per LW or SW, held stable by the frozen EX/MEM register
	assign memAccess = exMem.valid && (exMem.memRe || exMem.memWe);
	assign dCyc = memAccess;
	assign dStb = memAccess;
	assign dWe = memAccess && exMem.memWe;
	assign dAdr = exMem.result;
	assign dDatWr = exMem.storeData;

	// whole pipeline waits for the ack
	assign memHold = memAccess && !dAck;
	assign retire = exMem.valid && !memHold;

	// writeback
	assign wbWe = retire && exMem.regWe;
	assign wbAddr = exMem.dest;
	assign wbData = (exMem.wbSrc == wbLoad) ? dDatRd : exMem.result;

	always_ff @(posedge clk)
	begin
		if (reset)
			hlt <= 1'b0;
		else if (retire && exMem.halt)
			hlt <= 1'b1;
	end
endmodule

// ==== cpuTb.sv ====
module cpuTb import isaPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic iCyc;
	logic iStb;
	word_t iAdr;
	word_t iDatRd = '0;
	logic iAck = 1'b0;
	logic dCyc;
	logic dStb;
	logic dWe;
	word_t dAdr;
	word_t dDatWr;
	word_t dDatRd = '0;
	logic dAck = 1'b0;
	logic hlt;
	word_t pc;

	// bus memories and the images loaded into them during reset
	word_t imem [256];
	word_t dmem [256];
	word_t imemLoad [256];
	word_t dmemLoad [256];

	// golden records in file order
	logic [7:0] recKind [$];
	word_t recA [$];
	word_t recB [$];
	word_t expAdr [$];
	word_t expDat [$];

	logic [31:0] lfsr = 32'h6738;
	logic [1:0] iWait = '0;
	logic [1:0] dWait = '0;
	int valueErrors = 0;
	int otherErrors = 0;
	int totalInstr = 0;
	logic loaded = 1'b0;

	CPU #(.resetPc(16'h0000)) u_dut (
		.clk(clk), .reset(reset),
		.iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatRd(iDatRd), .iAck(iAck),
		.dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatWr(dDatWr),
		.dDatRd(dDatRd), .dAck(dAck), .hlt(hlt), .pc(pc));

	always #4 clk = ~clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// wait of 0 to 3 extra cycles, one step per bit
	task automatic drawWait(output logic [1:0] w);
		w = '0;
		for (int i = 0; i < 2; i++)
		begin
			lfsr = lfsrNext(lfsr);
			w = {w[0], lfsr[0]};
		end
	endtask

	task automatic checkValue(input word_t actual, input word_t expected, input string what);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic recordStore(input word_t adr, input word_t dat);
		if (expAdr.size() == 0)
		begin
			otherErrors++;
			$display("Extra store of %h to address %h at %0t ns", dat, adr, $time);
		end
		else
		begin
			checkValue(adr, expAdr.pop_front(), "store address");
			checkValue(dat, expDat.pop_front(), "store data");
		end
	endtask

	// unloaded instruction words decode as HLT
	task automatic fillMemories();
		word_t w;
		for (int a = 0; a < 256; a++)
		begin
			w = a;
			imemLoad[a] = 16'hF000 | w;
			dmemLoad[a] = {~w[7:0], w[7:0]};
		end
	endtask

	// ***********************************************
	// golden file
	// ***********************************************
	task automatic loadGolden();
		int fd;
		int n;
		int c;
		logic [7:0] kind;
		word_t a;
		word_t b;
		fd = $fopen("programGolden.txt", "r");
		if (fd == 0)
		begin
			otherErrors++;
			$display("Cannot open programGolden.txt");
			return;
		end
		while (!$feof(fd))
		begin
			n = $fscanf(fd, " %c", kind);
			if (n != 1)
				break;
			b = '0;
			if (kind == "#")
			begin
				c = $fgetc(fd);
				while (c != 10 && c != -1)
					c = $fgetc(fd);
			end
			else if (kind == "F" || kind == "I" || kind == "D" || kind == "S")
			begin
				if (kind == "F")
					n = $fscanf(fd, " %h", a) + 1;
				else
					n = $fscanf(fd, " %h %h", a, b);
				if (n != 2)
				begin
					otherErrors++;
					$display("Malformed %s record in programGolden.txt", kind);
					break;
				end
				recKind.push_back(kind);
				recA.push_back(a);
				recB.push_back(b);
				if (kind == "I")
					totalInstr++;
			end
			else
			begin
				otherErrors++;
				$display("Unknown record kind %s in programGolden.txt", kind);
				break;
			end
		end
		$fclose(fd);
	endtask

	// ***********************************************
	// bus memory models
	// ***********************************************
	always @(negedge clk)
	begin
		if (reset)
		begin
			for (int a = 0; a < 256; a++)
			begin
				imem[a] = imemLoad[a];
				dmem[a] = dmemLoad[a];
			end
			iAck <= 1'b0;
			dAck <= 1'b0;
		end
		else
		begin
			if (!iStb || iAck)
			begin
				iAck <= 1'b0;
				drawWait(iWait);
			end
			else if (iWait == '0)
			begin
				iAck <= 1'b1;
				iDatRd <= imem[iAdr[7:0]];
			end
			else
				iWait = iWait - 2'd1;

			if (!dStb || dAck)
			begin
				dAck <= 1'b0;
				drawWait(dWait);
			end
			else if (dWait == '0)
			begin
				dAck <= 1'b1;
				if (dWe)
				begin
					recordStore(dAdr, dDatWr);
					dmem[dAdr[7:0]] = dDatWr;
				end
				else
					dDatRd <= dmem[dAdr[7:0]];
			end
			else
				dWait = dWait - 2'd1;
		end
	end

	task automatic runProgram(input int index, input word_t finalPc, input int instrCount);
		int cycles;
		@(negedge clk);
		reset = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		cycles = 0;
		while (!hlt && cycles < 100 * instrCount)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!hlt)
		begin
			otherErrors++;
			$display("Program %0d never raised hlt", index);
		end
		else
		begin
			// every store is older than the HLT
			if (expAdr.size() != 0)
			begin
				otherErrors++;
				$display("Program %0d halted with %0d stores missing", index, expAdr.size());
			end
			checkValue(pc, finalPc, $sformatf("final pc of program %0d", index));
		end
		// stray stores after the halt show up as extra
		repeat (4) @(negedge clk);
		expAdr.delete();
		expDat.delete();
	endtask

	initial
	begin
		int prog;
		int progInstr;
		word_t adr;
		prog = 0;
		progInstr = 0;
		loadGolden();
		if (recKind.size() == 0)
		begin
			otherErrors++;
			$display("No program records were read from programGolden.txt");
		end
		loaded = 1'b1;
		fillMemories();
		for (int r = 0; r < recKind.size(); r++)
		begin
			adr = recA[r];
			case (recKind[r])
				"I":
				begin
					imemLoad[adr[7:0]] = recB[r];
					progInstr++;
				end
				"D":
					dmemLoad[adr[7:0]] = recB[r];
				"S":
				begin
					expAdr.push_back(adr);
					expDat.push_back(recB[r]);
				end
				default:
				begin
					runProgram(prog, adr, progInstr);
					prog++;
					progInstr = 0;
					fillMemories();
				end
			endcase
		end
		$display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
			valueErrors, otherErrors, u_dut.u_checker.failCount);
		if (valueErrors == 0 && otherErrors == 0 && u_dut.u_checker.failCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog sized from the instruction count, with room for the resets
	initial
	begin
		int limit;
		wait (loaded);
		limit = 40 * totalInstr * 5 + 100;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the programs finished", limit);
		$display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
			valueErrors, otherErrors, u_dut.u_checker.failCount);
		$display("Finished with errors");
		$finish;
	end
endmodule

// ==== cpu_checker.sv ====
module cpuChecker import isaPkg::*;
(
	input logic clk,
	input logic reset,
	input logic iCyc,
	input logic iStb,
	input word_t iAdr,
	input logic iAck,
	input logic dCyc,
	input logic dStb,
	input logic dWe,
	input word_t dAdr,
	input word_t dDatWr,
	input logic dAck,
	input logic hlt
);
	timeunit 1ns;
	timeprecision 100ps;

	// number of failed assertions
	int failCount = 0;

	// strobe only inside a bus cycle
	iStbInCyc: assert property (@(posedge clk) disable iff (reset) iStb |-> iCyc)
		else
		begin
			failCount++;
			$error("instruction bus strobe without cycle");
		end
	dStbInCyc: assert property (@(posedge clk) disable iff (reset) dStb |-> dCyc)
		else
		begin
			failCount++;
			$error("data bus strobe without cycle");
		end

	// request held steady until ack
	iHoldStable: assert property (@(posedge clk) disable iff (reset)
		iStb && !iAck |=> iStb && $stable(iAdr))
		else
		begin
			failCount++;
			$error("instruction bus request changed before ack");
		end
	dHoldStable: assert property (@(posedge clk) disable iff (reset)
		dStb && !dAck |=> dStb && $stable(dAdr) && $stable(dWe) && $stable(dDatWr))
		else
		begin
			failCount++;
			$error("data bus request changed before ack");
		end

	hltSticky: assert property (@(posedge clk) hlt && !reset |=> hlt)
		else
		begin
			failCount++;
			$error("hlt fell without reset");
		end

	idleAfterReset: assert property (@(posedge clk) reset |=> !iCyc && !dCyc && !hlt)
		else
		begin
			failCount++;
			$error("bus cycle or hlt active after reset");
		end
endmodule

bind CPU cpuChecker u_checker (.*);

// ==== isaPkg.sv ====
package isaPkg;

	// ***********************************************
	// words and register numbers
	// ***********************************************

	// data and addresses share one word since memory is word addressed
	typedef logic [15:0] word_t;

	// r0 always reads as zero
	typedef logic [3:0] regAddr_t;

	// ***********************************************
	// instruction encoding
	// ***********************************************

	// opcode sits in bits 15:12
	// codes not listed here decode as no-op
	typedef enum logic [3:0] {
		opAdd  = 4'd0,
		opSub  = 4'd1,
		opNand = 4'd2,
		opXor  = 4'd3,
		opSll  = 4'd4,
		opSrl  = 4'd5,
		opLw   = 4'd8,
		opSw   = 4'd9,
		opLlb  = 4'd10,
		opLhb  = 4'd11,
		opB    = 4'd12,
		opHlt  = 4'd15
	} opcode_t;

	// branch condition in bits 11:9
	typedef enum logic [2:0] {
		condNeq, condEq, condGt, condLt,
		condGte, condLte, condOv, condAlways
	} cond_t;

	function automatic opcode_t opOf(input word_t w);
		return opcode_t'(w[15:12]);
	endfunction

	function automatic regAddr_t rdOf(input word_t w);
		return w[11:8];
	endfunction

	function automatic regAddr_t rsOf(input word_t w);
		return w[7:4];
	endfunction

	// also the shift amount for SLL and SRL
	function automatic regAddr_t rtOf(input word_t w);
		return w[3:0];
	endfunction

	function automatic cond_t condOf(input word_t w);
		return cond_t'(w[11:9]);
	endfunction

endpackage

// ==== pipePkg.sv ====
package pipePkg;

	// ALU operation
	// the first six follow opcodes 0 to 5 so decode can take them straight from the opcode
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluNand,
		aluXor,
		aluSll,
		aluSrl,
		aluPassLow,
		aluMergeHigh
	} aluOp_t;

	// where the register write value comes from
	typedef enum logic {
		wbAlu,
		wbLoad
	} wbSrc_t;

	// instruction bus master
	typedef enum logic [1:0] {
		fetchIdle,
		fetchRequest,
		fetchHalted
	} fetchState_t;

endpackage

// ==== programGolden.txt ====
# columns: kind address value, all hex
# I instruction, D initial data, S expected store in bus order, F final pc (ends a program)
# program 0: ALU ops, load-use and back-to-back dependences
I 0000 A135
I 0001 B112
I 0002 A2F0
I 0003 0312
I 0004 1431
I 0005 2512
I 0006 3654
I 0007 4763
I 0008 5874
I 0009 9300
I 000A 9401
I 000B 9502
I 000C 9603
I 000D 9704
I 000E 9805
I 000F 9106
I 0010 9207
I 0011 AA22
I 0012 89AE
I 0013 0B99
I 0014 9BA1
I 0015 F000
D 0020 0F0F
S 0000 1225
S 0001 FFF0
S 0002 EDCF
S 0003 123F
S 0004 91F8
S 0005 091F
S 0006 1235
S 0007 FFF0
S 0023 1E1E
F 0016
# program 1: every branch condition taken and not taken, HLT in a taken branch shadow
I 0000 A15A
I 0001 A2FF
I 0002 B27F
I 0003 A301
I 0004 1433
I 0005 C001
I 0006 9100
I 0007 C201
I 0008 9101
I 0009 C401
I 000A 9102
I 000B C801
I 000C 9103
I 000D CA01
I 000E 9104
I 000F CC01
I 0010 9105
I 0011 0433
I 0012 C001
I 0013 9106
I 0014 C201
I 0015 9107
I 0016 C401
I 0017 9108
I 0018 C601
I 0019 9109
I 001A CA01
I 001B 910A
I 001C 1403
I 001D C601
I 001E 910B
I 001F C801
I 0020 910C
I 0021 0423
I 0022 CC01
I 0023 910D
I 0024 CE01
I 0025 F000
I 0026 910E
I 0027 F000
S 0000 005A
S 0002 005A
S 0005 005A
S 0007 005A
S FFF9 005A
S FFFA 005A
S FFFC 005A
S FFFE 005A
F 0028

// ==== sim.f ====
isaPkg.sv
pipePkg.sv
stageIf.sv
InstructionFetch.sv
InstructionDecode.sv
Execute.sv
Memory.sv
CPU.sv
cpu_checker.sv
cpuTb.sv

// ==== stageIf.sv ====
// ID/EX pipeline register
interface idExIf import isaPkg::*, pipePkg::*; ();
	logic valid;
	opcode_t opcode;
	aluOp_t aluOp;
	word_t opA;
	word_t opB;
	word_t storeVal;
	word_t imm;
	regAddr_t dest;
	logic regWe;
	logic memRe;
	logic memWe;
	wbSrc_t wbSrc;
	cond_t cond;
	word_t pcNext;
	logic halt;

	modport producer (output valid, opcode, aluOp, opA, opB, storeVal, imm, dest,
		regWe, memRe, memWe, wbSrc, cond, pcNext, halt);
	modport consumer (input valid, opcode, aluOp, opA, opB, storeVal, imm, dest,
		regWe, memRe, memWe, wbSrc, cond, pcNext, halt);
endinterface

// EX/MEM pipeline register
interface exMemIf import isaPkg::*, pipePkg::*; ();
	logic valid;
	word_t result;
	word_t storeData;
	regAddr_t dest;
	logic regWe;
	logic memRe;
	logic memWe;
	wbSrc_t wbSrc;
	logic halt;

	modport producer (output valid, result, storeData, dest, regWe, memRe, memWe, wbSrc, halt);
	modport consumer (input valid, result, storeData, dest, regWe, memRe, memWe, wbSrc, halt);
	// pending destination seen by the decode interlock
	modport monitor (input valid, dest, regWe);
endinterface
